// File: conv1x1_pkg.sv
`default_nettype none

package conv1x1_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Datapath sizing
    ////////////////////////////////////////////////////////////////////////////

    // One pixel, weight, bias or result
    localparam int PIXEL_W = 16;

    // Pixels per vector, must be a power of two
    localparam int LANES = 4;

    // Adder tree depth, log2 of LANES
    localparam int TREE_STAGES = 2;

    // Rows per coefficient memory
    localparam int KRNL_MAX = 16;

    // log2 of KRNL_MAX
    localparam int KRNL_ADDR_W = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline latencies
    ////////////////////////////////////////////////////////////////////////////

    // Product register plus one register per tree level
    localparam int MAC_LATENCY = 1 + TREE_STAGES;

    // Fetch register, MAC, output register
    localparam int CONV_LATENCY = 2 + MAC_LATENCY;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [PIXEL_W-1:0] pixel_t;

    // Lane 0 sits in the low bits, same layout for data and weight rows
    typedef logic [LANES-1:0][PIXEL_W-1:0] pixel_vec_t;

    typedef logic [KRNL_ADDR_W-1:0] krnl_addr_t;

    // Operand source for the multiply
    typedef enum logic [1:0] {
        SRC_PM_SUM  = 2'd0,
        SRC_RM0_SUM = 2'd1,
        SRC_RM1_SUM = 2'd2,
        SRC_CONVMAP = 2'd3
    } src_sel_t;

endpackage

`default_nettype wire

// File: coef_ram.sv
`timescale 1ns/1ps
`default_nettype none

module coef_ram #(
    parameter type word_t = logic [15:0],
    parameter int  DEPTH  = 16
) (
    input  wire logic                    clk_FAS,
    input  wire logic                    reset,
    input  wire logic                    load_restart,
    input  wire logic                    wren,
    input  wire word_t                   wr_data,
    input  wire logic                    rden,
    input  wire conv1x1_pkg::krnl_addr_t rd_addr,
    output word_t                        rd_data
);

    // Pointer needs one extra count so a full memory is visible
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int PTR_W  = $clog2(DEPTH + 1);

    word_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;

    // Host load, sequential addresses from zero
    always_ff @(posedge clk_FAS) begin
        if (reset || load_restart) begin
            wr_ptr <= '0;
        end else if (wren) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Writes past the end are dropped
    always_ff @(posedge clk_FAS) begin
        if (wren && (wr_ptr < DEPTH)) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
        end
    end

    // Registered read, holds last word between reads
    always_ff @(posedge clk_FAS) begin
        if (rden) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Host never loads more rows than the memory holds
    a_no_overflow : assert property (@(posedge clk_FAS) disable iff (reset)
        wren && !load_restart |-> wr_ptr != PTR_W'(DEPTH));

endmodule

`default_nettype wire

// File: conv1x1_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module conv1x1_fetch (
    input  wire logic                          clk_FAS,
    input  wire logic                          reset,
    input  wire logic                          start,
    input  wire conv1x1_pkg::src_sel_t         src_sel,
    input  wire logic [conv1x1_pkg::KRNL_ADDR_W:0] num_kernels,
    input  wire conv1x1_pkg::pixel_vec_t       pm_sum,
    input  wire conv1x1_pkg::pixel_vec_t       rm0_sum,
    input  wire conv1x1_pkg::pixel_vec_t       rm1_sum,
    input  wire conv1x1_pkg::pixel_vec_t       convmap_dout,
    output conv1x1_pkg::pixel_vec_t            operand_vec,
    output logic                               operand_vld,
    output logic                               rden,
    output conv1x1_pkg::krnl_addr_t            rd_addr
);

    conv1x1_pkg::pixel_vec_t   sel_vec;
    conv1x1_pkg::krnl_addr_t   krnl_idx;
    logic [conv1x1_pkg::KRNL_ADDR_W:0] idx_plus_one;
    logic                      last_krnl;

    ////////////////////////////////////////////////////////////////////////////
    // Operand source
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (src_sel)
            conv1x1_pkg::SRC_PM_SUM:  sel_vec = pm_sum;
            conv1x1_pkg::SRC_RM0_SUM: sel_vec = rm0_sum;
            conv1x1_pkg::SRC_RM1_SUM: sel_vec = rm1_sum;
            default:                  sel_vec = convmap_dout;
        endcase
    end

    // Vector lines up with memory read data one cycle on
    always_ff @(posedge clk_FAS) begin
        if (start) begin
            operand_vec <= sel_vec;
        end
    end

    always_ff @(posedge clk_FAS) begin
        if (reset) begin
            operand_vld <= 1'b0;
        end else begin
            operand_vld <= start;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Kernel index
    ////////////////////////////////////////////////////////////////////////////

    // Read issued in the start cycle, memory registers it
    assign rden    = start;
    assign rd_addr = krnl_idx;

    // Count compare one bit wider than the index
    assign idx_plus_one = {1'b0, krnl_idx} + 1'b1;
    assign last_krnl    = (idx_plus_one == num_kernels);

    always_ff @(posedge clk_FAS) begin
        if (reset) begin
            krnl_idx <= '0;
        end else if (start) begin
            // Wrap after num_kernels rows
            krnl_idx <= last_krnl ? '0 : idx_plus_one[conv1x1_pkg::KRNL_ADDR_W-1:0];
        end
    end

    a_start_known : assert property (@(posedge clk_FAS) disable iff (reset)
        !$isunknown(start));

    a_src_sel_known : assert property (@(posedge clk_FAS) disable iff (reset)
        start |-> !$isunknown(src_sel));

endmodule

`default_nettype wire

// File: lane_mac.sv
`timescale 1ns/1ps
`default_nettype none

module lane_mac (
    input  wire logic                    clk_FAS,
    input  wire logic                    reset,
    input  wire conv1x1_pkg::pixel_vec_t operand_vec,
    input  wire conv1x1_pkg::pixel_vec_t weight_row,
    input  wire logic                    operand_vld,
    output conv1x1_pkg::pixel_t          sum,
    output logic                         sum_vld
);

    localparam int LANES   = conv1x1_pkg::LANES;
    localparam int N_NODES = 2 * LANES - 1;
    localparam int LAT     = conv1x1_pkg::MAC_LATENCY;

    // Heap ordered tree
    // Root at 0, children of k at 2k+1 and 2k+2
    // Leaves at LANES-1 upward hold the products
    conv1x1_pkg::pixel_t node [N_NODES];

    // Valid bit per register level
    logic [LAT-1:0] vld_pipe;

    ////////////////////////////////////////////////////////////////////////////
    // Multiply and reduce
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_FAS) begin
        // Products truncated to pixel width
        for (int i = 0; i < LANES; i++) begin
            node[LANES-1+i] <= operand_vec[i] * weight_row[i];
        end
        // Balanced tree, so each level is exactly one register stage
        for (int k = 0; k < LANES - 1; k++) begin
            node[k] <= node[2*k+1] + node[2*k+2];
        end
    end

    assign sum = node[0];

    ////////////////////////////////////////////////////////////////////////////
    // Valid tracking
    ////////////////////////////////////////////////////////////////////////////

    // New vector may enter every cycle
    always_ff @(posedge clk_FAS) begin
        if (reset) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[LAT-2:0], operand_vld};
        end
    end

    assign sum_vld = vld_pipe[LAT-1];

endmodule

`default_nettype wire

// File: bias_add.sv
`timescale 1ns/1ps
`default_nettype none

module bias_add (
    input  wire logic                clk_FAS,
    input  wire logic                reset,
    input  wire conv1x1_pkg::pixel_t sum,
    input  wire logic                sum_vld,
    input  wire conv1x1_pkg::pixel_t bias_word,
    input  wire logic                bias_en,
    output conv1x1_pkg::pixel_t      conv_out,
    output logic                     out_vld
);

    localparam int LAT = conv1x1_pkg::MAC_LATENCY;

    // Bias read lands with the operands and runs MAC_LATENCY ahead of its sum
    conv1x1_pkg::pixel_t bias_dly [LAT];
    conv1x1_pkg::pixel_t bias_aligned;

    ////////////////////////////////////////////////////////////////////////////
    // Bias alignment
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_FAS) begin
        bias_dly[0] <= bias_word;
        for (int i = 1; i < LAT; i++) begin
            bias_dly[i] <= bias_dly[i-1];
        end
    end

    assign bias_aligned = bias_dly[LAT-1];

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    // Modulo 2^PIXEL_W add
    always_ff @(posedge clk_FAS) begin
        if (sum_vld) begin
            conv_out <= bias_en ? (sum + bias_aligned) : sum;
        end
    end

    always_ff @(posedge clk_FAS) begin
        if (reset) begin
            out_vld <= 1'b0;
        end else begin
            out_vld <= sum_vld;
        end
    end

    // Every output pulse carries a known result
    a_out_known : assert property (@(posedge clk_FAS) disable iff (reset)
        out_vld |-> !$isunknown(conv_out));

endmodule

`default_nettype wire

// File: conv1x1_pip.sv
`timescale 1ns/1ps
`default_nettype none

module conv1x1_pip (
    input  wire logic                              clk_FAS,
    input  wire logic                              reset,
    // Run control
    input  wire logic                              start,
    input  wire conv1x1_pkg::src_sel_t             src_sel,
    input  wire logic                              bias_en,
    input  wire logic [conv1x1_pkg::KRNL_ADDR_W:0] num_kernels,
    // Source vectors, valid with start
    input  wire conv1x1_pkg::pixel_vec_t           pm_sum,
    input  wire conv1x1_pkg::pixel_vec_t           rm0_sum,
    input  wire conv1x1_pkg::pixel_vec_t           rm1_sum,
    input  wire conv1x1_pkg::pixel_vec_t           convmap_dout,
    // Coefficient load
    input  wire logic                              weight_wren,
    input  wire conv1x1_pkg::pixel_vec_t           weight_din,
    input  wire logic                              bias_wren,
    input  wire conv1x1_pkg::pixel_t               bias_din,
    input  wire logic                              load_restart,
    // Result
    output conv1x1_pkg::pixel_t                    conv_out,
    output logic                                   out_vld
);

    conv1x1_pkg::pixel_vec_t operand_vec;
    logic                    operand_vld;
    logic                    rden;
    conv1x1_pkg::krnl_addr_t rd_addr;
    conv1x1_pkg::pixel_vec_t weight_row;
    conv1x1_pkg::pixel_t     bias_word;
    conv1x1_pkg::pixel_t     sum;
    logic                    sum_vld;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch and coefficient memories
    ////////////////////////////////////////////////////////////////////////////

    conv1x1_fetch i_fetch (
        .clk_FAS      (clk_FAS),
        .reset        (reset),
        .start        (start),
        .src_sel      (src_sel),
        .num_kernels  (num_kernels),
        .pm_sum       (pm_sum),
        .rm0_sum      (rm0_sum),
        .rm1_sum      (rm1_sum),
        .convmap_dout (convmap_dout),
        .operand_vec  (operand_vec),
        .operand_vld  (operand_vld),
        .rden         (rden),
        .rd_addr      (rd_addr)
    );

    // One weight row per kernel
    coef_ram #(
        .word_t (conv1x1_pkg::pixel_vec_t),
        .DEPTH  (conv1x1_pkg::KRNL_MAX)
    ) i_weight_ram (
        .clk_FAS      (clk_FAS),
        .reset        (reset),
        .load_restart (load_restart),
        .wren         (weight_wren),
        .wr_data      (weight_din),
        .rden         (rden),
        .rd_addr      (rd_addr),
        .rd_data      (weight_row)
    );

    // One bias per kernel, read alongside the weights
    coef_ram #(
        .word_t (conv1x1_pkg::pixel_t),
        .DEPTH  (conv1x1_pkg::KRNL_MAX)
    ) i_bias_ram (
        .clk_FAS      (clk_FAS),
        .reset        (reset),
        .load_restart (load_restart),
        .wren         (bias_wren),
        .wr_data      (bias_din),
        .rden         (rden),
        .rd_addr      (rd_addr),
        .rd_data      (bias_word)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Arithmetic
    ////////////////////////////////////////////////////////////////////////////

    lane_mac i_lane_mac (
        .clk_FAS     (clk_FAS),
        .reset       (reset),
        .operand_vec (operand_vec),
        .weight_row  (weight_row),
        .operand_vld (operand_vld),
        .sum         (sum),
        .sum_vld     (sum_vld)
    );

    bias_add i_bias_add (
        .clk_FAS   (clk_FAS),
        .reset     (reset),
        .sum       (sum),
        .sum_vld   (sum_vld),
        .bias_word (bias_word),
        .bias_en   (bias_en),
        .conv_out  (conv_out),
        .out_vld   (out_vld)
    );

endmodule

`default_nettype wire

// File: tb_conv1x1_pip.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv1x1_pip;

    localparam int LANES    = conv1x1_pkg::LANES;
    localparam int KRNL_MAX = conv1x1_pkg::KRNL_MAX;
    localparam int CONV_LAT = conv1x1_pkg::CONV_LATENCY;

    // Stimulus sizes
    localparam int RESET_CYCLES = 5;
    localparam int NUM_K        = 5;
    localparam int WRAP_K       = 3;
    localparam int N_SPARSE     = 40;
    localparam int N_WRAP       = 10;
    localparam int N_B2B        = 30;
    localparam int N_RELOAD     = 12;
    localparam int MAX_GAP      = 4;

    // Worst case stimulus length including loads and drains
    localparam int STIM_CYCLES = RESET_CYCLES + 8 + 3 * (NUM_K + 2)
        + (2 * N_SPARSE + N_WRAP + N_RELOAD) * (1 + MAX_GAP) + N_B2B
        + 5 * (CONV_LAT + 4);
    localparam int TIMEOUT = 4 * (STIM_CYCLES + CONV_LAT);

    logic                              clk_FAS;
    logic                              reset;
    logic                              start;
    conv1x1_pkg::src_sel_t             src_sel;
    logic                              bias_en;
    logic [conv1x1_pkg::KRNL_ADDR_W:0] num_kernels;
    conv1x1_pkg::pixel_vec_t           pm_sum;
    conv1x1_pkg::pixel_vec_t           rm0_sum;
    conv1x1_pkg::pixel_vec_t           rm1_sum;
    conv1x1_pkg::pixel_vec_t           convmap_dout;
    logic                              weight_wren;
    conv1x1_pkg::pixel_vec_t           weight_din;
    logic                              bias_wren;
    conv1x1_pkg::pixel_t               bias_din;
    logic                              load_restart;
    conv1x1_pkg::pixel_t               conv_out;
    logic                              out_vld;

    // Reference copy of both memories and the kernel counter
    conv1x1_pkg::pixel_vec_t model_w [KRNL_MAX];
    conv1x1_pkg::pixel_t     model_b [KRNL_MAX];
    int                      model_wptr;
    int                      model_bptr;
    int                      model_kidx;

    // Expected results with the oldest first
    int                      due_q  [$];
    conv1x1_pkg::pixel_t     val_q  [$];
    string                   name_q [$];

    int    seed;
    int    cyc;
    int    watchdog;
    int    check_cnt;
    int    mismatch_cnt;
    int    vld_err_cnt;
    string test_name;

    conv1x1_pip i_dut (.*);

    always #4 clk_FAS = ~clk_FAS;

    ////////////////////////////////////////////////////////////////////////////
    // Reference arithmetic
    ////////////////////////////////////////////////////////////////////////////

    function automatic conv1x1_pkg::pixel_vec_t rand_vec();
        conv1x1_pkg::pixel_vec_t v;
        for (int l = 0; l < LANES; l++) begin
            v[l] = conv1x1_pkg::pixel_t'($random(seed));
        end
        return v;
    endfunction

    function automatic conv1x1_pkg::pixel_vec_t pick_source(input conv1x1_pkg::src_sel_t sel);
        case (sel)
            conv1x1_pkg::SRC_PM_SUM:  return pm_sum;
            conv1x1_pkg::SRC_RM0_SUM: return rm0_sum;
            conv1x1_pkg::SRC_RM1_SUM: return rm1_sum;
            default:                  return convmap_dout;
        endcase
    endfunction

    // Dot product of one vector with one row in 16-bit wraparound
    function automatic conv1x1_pkg::pixel_t expected_pixel(
        input conv1x1_pkg::pixel_vec_t src,
        input conv1x1_pkg::pixel_vec_t wrow,
        input conv1x1_pkg::pixel_t     b,
        input logic                    add_bias
    );
        conv1x1_pkg::pixel_t acc;
        acc = '0;
        for (int l = 0; l < LANES; l++) begin
            acc = acc + src[l] * wrow[l];
        end
        if (add_bias) begin
            acc = acc + b;
        end
        return acc;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Model and output check at mid cycle where everything is stable
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_FAS) begin
        cyc = cyc + 1;
        if (due_q.size() != 0 && due_q[0] == cyc) begin
            check_cnt = check_cnt + 1;
            assert (out_vld === 1'b1) else begin
                vld_err_cnt = vld_err_cnt + 1;
                $display("Missing output valid in %s at cycle %0d", name_q[0], cyc);
            end
            if (out_vld === 1'b1) begin
                assert (conv_out === val_q[0]) else begin
                    mismatch_cnt = mismatch_cnt + 1;
                    $display("Mismatch in %s: expected %h, actual %h",
                             name_q[0], val_q[0], conv_out);
                end
            end
            void'(due_q.pop_front());
            void'(val_q.pop_front());
            void'(name_q.pop_front());
        end else begin
            // Covers reset, idle gaps and extra pulses
            assert (out_vld === 1'b0) else begin
                vld_err_cnt = vld_err_cnt + 1;
                $display("Unexpected output valid at cycle %0d during %s", cyc, test_name);
            end
        end
        // Inputs seen here are sampled by the DUT at the next edge
        if (reset) begin
            model_kidx = 0;
            model_wptr = 0;
            model_bptr = 0;
        end else begin
            if (start) begin
                due_q.push_back(cyc + CONV_LAT);
                val_q.push_back(expected_pixel(pick_source(src_sel), model_w[model_kidx],
                                               model_b[model_kidx], bias_en));
                name_q.push_back(test_name);
                // Wrap after the last kernel
                if (model_kidx == int'(num_kernels) - 1) begin
                    model_kidx = 0;
                end else begin
                    model_kidx = model_kidx + 1;
                end
            end
            if (weight_wren && model_wptr < KRNL_MAX) begin
                model_w[model_wptr] = weight_din;
            end
            if (bias_wren && model_bptr < KRNL_MAX) begin
                model_b[model_bptr] = bias_din;
            end
            model_wptr = load_restart ? 0 : model_wptr + int'(weight_wren);
            model_bptr = load_restart ? 0 : model_bptr + int'(bias_wren);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_FAS);
            start        <= 1'b0;
            weight_wren  <= 1'b0;
            bias_wren    <= 1'b0;
            load_restart <= 1'b0;
        end
    endtask

    task automatic restart_load();
        @(posedge clk_FAS);
        load_restart <= 1'b1;
        idle(1);
    endtask

    task automatic write_weights(input int n);
        repeat (n) begin
            @(posedge clk_FAS);
            weight_wren <= 1'b1;
            weight_din  <= rand_vec();
        end
        idle(1);
    endtask

    task automatic write_biases(input int n);
        repeat (n) begin
            @(posedge clk_FAS);
            bias_wren <= 1'b1;
            bias_din  <= conv1x1_pkg::pixel_t'($random(seed));
        end
        idle(1);
    endtask

    // Sources rotate per start with a random idle gap when sparse
    task automatic run_starts(input int n, input bit sparse);
        int gap;
        for (int i = 0; i < n; i++) begin
            @(posedge clk_FAS);
            start        <= 1'b1;
            src_sel      <= conv1x1_pkg::src_sel_t'(i % 4);
            pm_sum       <= rand_vec();
            rm0_sum      <= rand_vec();
            rm1_sum      <= rand_vec();
            convmap_dout <= rand_vec();
            if (sparse) begin
                gap = 1 + int'({$random(seed)} % MAX_GAP);
                idle(gap);
            end
        end
        idle(1);
    endtask

    // Wait until every expected result has come due
    task automatic drain();
        while (due_q.size() != 0) begin
            @(posedge clk_FAS);
        end
        idle(2);
    endtask

    initial begin
        seed         = 48598;
        cyc          = 0;
        check_cnt    = 0;
        mismatch_cnt = 0;
        vld_err_cnt  = 0;
        test_name    = "reset";
        clk_FAS      = 1'b0;
        reset        = 1'b1;
        start        = 1'b0;
        src_sel      = conv1x1_pkg::SRC_PM_SUM;
        bias_en      = 1'b0;
        num_kernels  = (conv1x1_pkg::KRNL_ADDR_W + 1)'(NUM_K);
        pm_sum       = '0;
        rm0_sum      = '0;
        rm1_sum      = '0;
        convmap_dout = '0;
        weight_wren  = 1'b0;
        weight_din   = '0;
        bias_wren    = 1'b0;
        bias_din     = '0;
        load_restart = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_FAS);
        reset <= 1'b0;
        idle(6);

        test_name = "no_bias";
        restart_load();
        write_weights(NUM_K);
        run_starts(N_SPARSE, 1'b1);
        drain();

        // bias_en only changes with the pipeline empty
        test_name = "bias";
        bias_en <= 1'b1;
        write_biases(NUM_K);
        run_starts(N_SPARSE, 1'b1);
        drain();

        // Index is back at zero here, so a smaller count is safe
        test_name = "kernel_wrap";
        num_kernels <= (conv1x1_pkg::KRNL_ADDR_W + 1)'(WRAP_K);
        run_starts(N_WRAP, 1'b1);
        drain();

        test_name = "back_to_back";
        run_starts(N_B2B, 1'b0);
        drain();

        test_name = "reload";
        restart_load();
        write_weights(NUM_K);
        run_starts(N_RELOAD, 1'b1);
        drain();

        $display("Checks %0d, mismatches %0d, valid errors %0d",
                 check_cnt, mismatch_cnt, vld_err_cnt);
        if (mismatch_cnt + vld_err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run limit
    initial begin
        watchdog = 0;
        while (watchdog < TIMEOUT) begin
            @(posedge clk_FAS);
            watchdog = watchdog + 1;
        end
        $display("Timeout: test did not finish within %0d cycles", TIMEOUT);
        $display("Checks %0d, mismatches %0d, valid errors %0d",
                 check_cnt, mismatch_cnt, vld_err_cnt);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
conv1x1_pkg.sv
coef_ram.sv
conv1x1_fetch.sv
lane_mac.sv
bias_add.sv
conv1x1_pip.sv
tb_conv1x1_pip.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_conv1x1_pip
FILELIST  := compile.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Finished with no errors

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
